/* decodeStage.f */
+incdir+tb
design/decodePkg.sv
design/registerFile.sv
design/branchResolve.sv
design/linkWriteSteer.sv
design/decodeStage.sv
tb/decodeStageTb.sv

/* runSim.sh */
#!/bin/sh
# Builds the decode stage testbench with Verilator and runs it
# The exit status is the simulator's own, so a failed check fails the script

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
   echo "verilator was not found on the PATH"
   exit 1
fi

if ! verilator --binary --timing -f decodeStage.f --top-module decodeStageTb \
      -o decodeStageSim; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/decodeStageSim
status=$?
if [ "$status" -ne 0 ]; then
   echo "Simulation ended with status $status"
fi
exit "$status"

/* tb/decodeRefModel.svh */
/*
   Decode stage reference model. Mirrors the register file and the
   jump-and-link tracker and predicts read data and PC select from them.
*/
`ifndef DECODE_REF_MODEL_SVH
`define DECODE_REF_MODEL_SVH

   wordT mirrorRegs [8];  // Expected register contents after the last edge
   logic mirrorExJl;      // Jump-and-link one stage past decode
   logic mirrorMemJl;
   logic mirrorWbJl;      // Its own writeback is due now and is dropped

   // Major opcode of the instruction on the DUT input
   function automatic logic [4:0] refOpcode();
      return instr[15:11];
   endfunction

   // Either jump-and-link form sitting in decode
   function automatic logic refLinkNow();
      return (refOpcode() == opJal) || (refOpcode() == opJalr);
   endfunction

   // Link writes take the port in decode and again one cycle later
   function automatic logic refWriteEnable();
      return (writeEn && !mirrorWbJl) || refLinkNow() || mirrorExJl;
   endfunction

   function automatic regAddrT refWriteAddr();
      if (refLinkNow() || mirrorExJl) return 3'd7;  // Register 7 holds return addresses
      return writeRegAddr;
   endfunction

   function automatic wordT refWriteData();
      if (link || refLinkNow() || mirrorExJl) return pcNow + 16'd2;  // Next halfword
      if (lbi) return imm;
      return writeback;
   endfunction

   // JAL takes its first operand from the link register
   function automatic regAddrT refRead1Addr();
      if (refOpcode() == opJal) return 3'd7;
      return instr[10:8];
   endfunction

   // A read of the register being written sees the new value
   function automatic wordT refReadData(input regAddrT addr);
      if (refWriteEnable() && (refWriteAddr() == addr)) return refWriteData();
      return mirrorRegs[addr];
   endfunction

   function automatic logic refPcSel();
      wordT op1;
      logic taken;

      op1   = refReadData(refRead1Addr());
      taken = 1'b0;
      case (refOpcode())
         opBeqz:  taken = (op1 == 16'h0000);
         opBnez:  taken = (op1 != 16'h0000);
         opBltz:  taken = op1[15];   // Negative in two's complement
         opBgez:  taken = !op1[15];
         default: taken = 1'b0;      // Not a conditional branch
      endcase
      return !halt && (taken || jump);
   endfunction

   task automatic refReset();
      mirrorRegs  = '{default: '0};
      mirrorExJl  = 1'b0;
      mirrorMemJl = 1'b0;
      mirrorWbJl  = 1'b0;
   endtask

   // Advance the mirror by one clock using the inputs held for that edge
   task automatic refStep();
      logic    doWrite;
      regAddrT dest;
      wordT    value;

      doWrite = refWriteEnable();
      dest    = refWriteAddr();
      value   = refWriteData();
      if (doWrite) begin
         mirrorRegs[dest] = value;
      end
      mirrorWbJl  = mirrorMemJl;
      mirrorMemJl = mirrorExJl;
      mirrorExJl  = refLinkNow();  // Tracker moves one stage per clock
   endtask

`endif

/* tb/decodeStageTb.sv */
/*
   Decode stage testbench. Applies directed and LFSR random stimulus and
   checks both read ports and PC select against a reference model.
*/
`timescale 1ns/1ns

module decodeStageTb import decodePkg::*; ();

   localparam int randomCycles = 400;
   localparam int maxCycles    = 1000;  // Bound on the checking loop
   localparam int resetTimeout = 20;

   localparam logic [4:0] opNop = 5'b00000;  // Decodes as no branch and no link

   // Control flags for directed vectors
   localparam logic [4:0] flagNone  = 5'b00000;
   localparam logic [4:0] flagWrite = 5'b00001;
   localparam logic [4:0] flagLbi   = 5'b00010;
   localparam logic [4:0] flagLink  = 5'b00100;
   localparam logic [4:0] flagJump  = 5'b01000;
   localparam logic [4:0] flagHalt  = 5'b10000;

   logic    clk;
   logic    reset;
   wordT    instr;
   wordT    pcNow;
   wordT    imm;
   wordT    writeback;
   regAddrT writeRegAddr;
   logic    lbi;
   logic    link;
   logic    jump;
   logic    halt;
   logic    writeEn;
   wordT    reg1Data;
   wordT    reg2Data;
   logic    pcSel;

   logic [31:0] lfsrState;  // Random source, one step per bit taken
   logic        stimDone;   // Set once the last vector has been clocked

   `include "decodeRefModel.svh"

   decodeStage decodeStage_inst (
      .clk          (clk),
      .reset        (reset),
      .instr        (instr),
      .pcNow        (pcNow),
      .imm          (imm),
      .writeback    (writeback),
      .writeRegAddr (writeRegAddr),
      .lbi          (lbi),
      .link         (link),
      .jump         (jump),
      .halt         (halt),
      .writeEn      (writeEn),
      .reg1Data     (reg1Data),
      .reg2Data     (reg2Data),
      .pcSel        (pcSel)
   );

   always #50 clk = ~clk;  // 100 ns period

   // Galois form, taps for x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsrStep(input logic [31:0] state);
      if (state[0]) return (state >> 1) ^ 32'h8020_0003;
      return state >> 1;
   endfunction

   function automatic logic [15:0] randBits(input int count);
      logic [15:0] value;

      value = '0;
      for (int i = 0; i < count; i++) begin
         value     = (value << 1) | {15'b0, lfsrState[0]};
         lfsrState = lfsrStep(lfsrState);
      end
      return value;
   endfunction

   // Named opcodes come up far more often than a uniform draw would give
   function automatic logic [4:0] pickOpcode();
      logic [3:0] sel;

      sel = 4'(randBits(4));
      case (sel)
         4'd0:    return opJal;
         4'd1:    return opJalr;
         4'd2:    return opBeqz;
         4'd3:    return opBnez;
         4'd4:    return opBltz;
         4'd5:    return opBgez;
         default: return 5'(randBits(5));
      endcase
   endfunction

   function automatic wordT makeInstr(input logic [4:0] op, input regAddrT rsA,
                                      input regAddrT rtA);
      return {op, rsA, rtA, 5'b00000};
   endfunction

   // Inputs change a little after the rising edge
   task automatic nextSlot();
      @(posedge clk);
      #5;
   endtask

   task automatic applyVector(input wordT ins, input wordT pc, input wordT wbValue,
                              input wordT immValue, input regAddrT dest,
                              input logic [4:0] flags);
      instr        = ins;
      pcNow        = pc;
      writeback    = wbValue;
      imm          = immValue;
      writeRegAddr = dest;
      writeEn      = (flags & flagWrite) != 5'd0;
      lbi          = (flags & flagLbi) != 5'd0;
      link         = (flags & flagLink) != 5'd0;
      jump         = (flags & flagJump) != 5'd0;
      halt         = (flags & flagHalt) != 5'd0;
      nextSlot();
   endtask

   task automatic randomVector();
      instr        = makeInstr(pickOpcode(), regAddrT'(randBits(3)), regAddrT'(randBits(3)));
      instr[4:0]   = 5'(randBits(5));        // Immediate bits, ignored by decode
      pcNow        = randBits(16) & 16'hfffe;  // Halfword aligned
      imm          = {8'h00, 8'(randBits(8))};
      writeback    = randBits(16);
      writeRegAddr = regAddrT'(randBits(3));
      writeEn      = (randBits(2) != 16'd0);
      lbi          = (randBits(2) == 16'd0);
      link         = (randBits(3) == 16'd0);
      jump         = (randBits(3) == 16'd0);
      halt         = (randBits(3) == 16'd0);
   endtask

   task automatic checkWord(input string name, input wordT actual, input wordT expected);
      if (actual !== expected) begin
         $display("MISMATCH %s: actual 0x%h expected 0x%h", name, actual, expected);
         $display("Verification failed");
         $fatal(1, "Check of %s failed", name);
      end
   endtask

   task automatic checkBit(input string name, input logic actual, input logic expected);
      if (actual !== expected) begin
         $display("MISMATCH %s: actual 0x%h expected 0x%h", name, actual, expected);
         $display("Verification failed");
         $fatal(1, "Check of %s failed", name);
      end
   endtask

   task automatic compareOutputs();
      checkWord("reg1Data", reg1Data, refReadData(refRead1Addr()));
      checkWord("reg2Data", reg2Data, refReadData(instr[7:5]));
      checkBit("pcSel", pcSel, refPcSel());
   endtask

   initial begin : stimulus
      clk       = 1'b0;
      reset     = 1'b1;
      stimDone  = 1'b0;
      lfsrState = 32'h6c84;
      instr     = makeInstr(opNop, 3'd0, 3'd0);
      pcNow     = '0;
      imm       = '0;
      writeback = '0;
      writeRegAddr = '0;
      {lbi, link, jump, halt, writeEn} = 5'b00000;

      repeat (3) @(posedge clk);
      #5;
      reset = 1'b0;

      // Every register reads zero after reset
      for (int i = 0; i < 8; i = i + 2) begin
         applyVector(makeInstr(opNop, regAddrT'(i), regAddrT'(i + 1)), 16'h0000, 16'h0000,
                     16'h0000, 3'd0, flagNone);
      end

      // Normal write seen through the bypass and then from storage
      applyVector(makeInstr(opNop, 3'd3, 3'd3), 16'h0040, 16'h1234, 16'h0055, 3'd3, flagWrite);
      applyVector(makeInstr(opNop, 3'd3, 3'd0), 16'h0042, 16'hdead, 16'h0000, 3'd3, flagNone);
      applyVector(makeInstr(opNop, 3'd4, 3'd4), 16'h0044, 16'hbeef, 16'h00ab, 3'd4,
                  flagWrite | flagLbi);  // Immediate wins over writeback
      applyVector(makeInstr(opNop, 3'd4, 3'd3), 16'h0046, 16'h0000, 16'h0000, 3'd0, flagNone);
      applyVector(makeInstr(opNop, 3'd5, 3'd5), 16'h0048, 16'h8000, 16'h0000, 3'd5, flagWrite);

      // Each branch on a zero, a positive and a negative operand
      applyVector(makeInstr(opBeqz, 3'd0, 3'd1), 16'h0050, 16'h0000, 16'h0000, 3'd0, flagNone);
      applyVector(makeInstr(opBeqz, 3'd3, 3'd1), 16'h0052, 16'h0000, 16'h0000, 3'd0, flagNone);
      applyVector(makeInstr(opBnez, 3'd3, 3'd1), 16'h0054, 16'h0000, 16'h0000, 3'd0, flagNone);
      applyVector(makeInstr(opBnez, 3'd0, 3'd1), 16'h0056, 16'h0000, 16'h0000, 3'd0, flagNone);
      applyVector(makeInstr(opBltz, 3'd5, 3'd1), 16'h0058, 16'h0000, 16'h0000, 3'd0, flagNone);
      applyVector(makeInstr(opBltz, 3'd3, 3'd1), 16'h005a, 16'h0000, 16'h0000, 3'd0, flagNone);
      applyVector(makeInstr(opBgez, 3'd3, 3'd1), 16'h005c, 16'h0000, 16'h0000, 3'd0, flagNone);
      applyVector(makeInstr(opBgez, 3'd5, 3'd1), 16'h005e, 16'h0000, 16'h0000, 3'd0, flagNone);
      applyVector(makeInstr(opNop, 3'd0, 3'd1), 16'h0060, 16'h0000, 16'h0000, 3'd0, flagJump);
      applyVector(makeInstr(opBeqz, 3'd0, 3'd1), 16'h0062, 16'h0000, 16'h0000, 3'd0,
                  flagJump | flagHalt);  // Halt beats both redirects

      // JAL writes r7 in decode and in EX, then drops its own writeback in WB
      applyVector(makeInstr(opJal, 3'd2, 3'd1), 16'h0100, 16'h7777, 16'h0000, 3'd2, flagWrite);
      applyVector(makeInstr(opNop, 3'd7, 3'd2), 16'h0102, 16'h6666, 16'h0000, 3'd2, flagWrite);
      applyVector(makeInstr(opNop, 3'd7, 3'd7), 16'h0104, 16'h0000, 16'h0000, 3'd0, flagNone);
      applyVector(makeInstr(opNop, 3'd2, 3'd7), 16'h0106, 16'h5555, 16'h0000, 3'd2, flagWrite);
      applyVector(makeInstr(opNop, 3'd2, 3'd7), 16'h0108, 16'h0000, 16'h0000, 3'd0, flagNone);

      // JALR keeps reading Rs on port 1
      applyVector(makeInstr(opJalr, 3'd3, 3'd7), 16'h0200, 16'h4444, 16'h0000, 3'd1, flagWrite);
      applyVector(makeInstr(opNop, 3'd1, 3'd7), 16'h0202, 16'h0000, 16'h0000, 3'd0, flagNone);
      applyVector(makeInstr(opNop, 3'd1, 3'd7), 16'h0204, 16'h0000, 16'h0000, 3'd0, flagNone);
      applyVector(makeInstr(opNop, 3'd1, 3'd7), 16'h0206, 16'h3333, 16'h0000, 3'd1, flagWrite);
      applyVector(makeInstr(opNop, 3'd1, 3'd7), 16'h0208, 16'h0000, 16'h0000, 3'd0, flagNone);

      // Link input stores the return address at the WB destination
      applyVector(makeInstr(opNop, 3'd6, 3'd6), 16'h0300, 16'h1111, 16'h0000, 3'd6,
                  flagWrite | flagLink);
      applyVector(makeInstr(opNop, 3'd6, 3'd6), 16'h0302, 16'h0000, 16'h0000, 3'd0, flagNone);

      repeat (randomCycles) begin
         randomVector();
         nextSlot();
      end
      stimDone = 1'b1;
   end

   // Compares at the falling edge, where every input and output is settled
   initial begin : checking
      int waitCount;
      int cycles;

      waitCount = 0;
      while (reset !== 1'b0 && waitCount < resetTimeout) begin
         @(negedge clk);
         waitCount++;
      end
      if (reset !== 1'b0) begin
         $display("Verification failed");
         $fatal(1, "Reset was not released within %0d cycles", resetTimeout);
      end

      refReset();  // Three reset edges have cleared the DUT state
      cycles = 0;
      while (stimDone !== 1'b1 && cycles < maxCycles) begin
         compareOutputs();
         refStep();
         cycles++;
         @(negedge clk);
      end

      if (stimDone === 1'b1) begin
         $display("Verification passed");
         $finish;
      end else begin
         $display("Verification failed");
         $fatal(1, "Stimulus did not finish within %0d checked cycles", maxCycles);
      end
   end

endmodule

/* design/decodeStage.sv */
/*
   Decode stage of the 16-bit five-stage processor. Splits the instruction
   into its fields, reads the two source registers, owns the register-file
   write port and resolves whether the PC is redirected.
*/
`timescale 1ns/1ns

module decodeStage import decodePkg::*; (
   input  logic    clk,
   input  logic    reset,         // Synchronous, active high
   input  wordT    instr,         // Instruction currently in decode
   input  wordT    pcNow,         // PC of that instruction
   input  wordT    imm,           // Immediate for load-byte-immediate
   input  wordT    writeback,     // Result arriving from WB
   input  regAddrT writeRegAddr,  // WB destination register
   input  logic    lbi,           // WB instruction is a load-byte-immediate
   input  logic    link,          // WB wants the return address stored
   input  logic    jump,          // Unconditional jump in decode
   input  logic    halt,          // Halt in progress
   input  logic    writeEn,       // WB writes a register
   output wordT    reg1Data,      // First operand (Rs or the link register)
   output wordT    reg2Data,      // Second operand (Rt)
   output logic    pcSel          // Redirect the PC this cycle
);

   opcodeT  opcode;     // Major opcode field
   regAddrT rs;         // First source field
   regAddrT rt;         // Second source field
   regAddrT read1Addr;  // First read address after link override
   regAddrT wrAddr;     // Steered write address
   wordT    wrData;     // Steered write data
   logic    wrEnable;   // Steered write strobe

   // Instruction fields
   // Opcode sits in the top five bits and the source registers follow it
   assign opcode = opcodeT'(instr[15:11]);
   assign rs     = instr[10:8];
   assign rt     = instr[7:5];  // Low five bits hold immediates not used here

   // Write steering also picks the first read address
   // A JAL needs the link register on port 1 instead of Rs
   linkWriteSteer linkWriteSteer_inst (
      .clk          (clk),
      .reset        (reset),
      .opcode       (opcode),
      .rs           (rs),
      .writeRegAddr (writeRegAddr),
      .pcNow        (pcNow),
      .imm          (imm),
      .writeback    (writeback),
      .lbi          (lbi),
      .link         (link),
      .writeEn      (writeEn),
      .read1Addr    (read1Addr),
      .wrAddr       (wrAddr),
      .wrData       (wrData),
      .wrEnable     (wrEnable)
   );

   // Register storage with bypass of the pending write
   registerFile registerFile_inst (
      .clk      (clk),
      .reset    (reset),
      .rd1Addr  (read1Addr),
      .rd2Addr  (rt),
      .wrAddr   (wrAddr),
      .wrData   (wrData),
      .wrEnable (wrEnable),
      .rd1Data  (reg1Data),
      .rd2Data  (reg2Data)
   );

   // Branch decision works on the first operand as read this cycle
   // Bypassed write data is therefore already visible to the condition test
   branchResolve branchResolve_inst (
      .opcode  (opcode),
      .operand (reg1Data),
      .jump    (jump),
      .halt    (halt),
      .pcSel   (pcSel)
   );

endmodule

/* design/linkWriteSteer.sv */
/*
   Jump-and-link write steering. Writes the return address into the link
   register while the jump-and-link is in decode, follows it down the pipe
   and blocks its own writeback when it reaches WB.
*/
`timescale 1ns/1ns

module linkWriteSteer import decodePkg::*; (
   input  logic    clk,
   input  logic    reset,         // Synchronous, clears the tracker
   input  opcodeT  opcode,        // Opcode of the instruction in decode
   input  regAddrT rs,            // First source field of the instruction
   input  regAddrT writeRegAddr,  // Destination of the instruction in WB
   input  wordT    pcNow,         // PC of the instruction in decode
   input  wordT    imm,           // Load-byte-immediate value
   input  wordT    writeback,     // Result from the WB stage
   input  logic    lbi,           // Store imm instead of writeback
   input  logic    link,          // Store the return address at writeRegAddr
   input  logic    writeEn,       // WB stage wants a register write
   output regAddrT read1Addr,     // Address for the first read port
   output regAddrT wrAddr,
   output wordT    wrData,
   output logic    wrEnable
);

   logic linkNow;     // Jump-and-link currently in decode
   logic exJl;        // Jump-and-link now in EX
   logic memJl;       // Jump-and-link now in MEM
   logic wbJl;        // Jump-and-link now in WB
   logic linkWrite;   // Link register owns the write port this cycle
   wordT returnAddr;
   wordT normalData;  // Data of the ordinary writeback path

   // Both jump-and-link forms store a return address
   assign linkNow = (opcode == opJal) || (opcode == opJalr);

   // JAL reads the link register as its first operand, everything else reads Rs
   assign read1Addr = (opcode == opJal) ? linkReg : rs;

   // The flag moves one stage per clock with no stall input
   // So wbJl rises exactly three cycles after linkNow
   always_ff @(posedge clk) begin
      if (reset) begin
         exJl  <= 1'b0;
         memJl <= 1'b0;
         wbJl  <= 1'b0;
      end else begin
         exJl  <= linkNow;
         memJl <= exJl;
         wbJl  <= memJl;
      end
   end

   // Return address is the instruction after the one in decode
   assign returnAddr = pcNow + pcIncrement;

   // The link write happens in decode and is repeated while the instruction is in EX
   assign linkWrite = linkNow || exJl;

   // Ordinary source is either the immediate byte or the WB result
   assign normalData = lbi ? imm : writeback;

   // Link input also selects the return address even without a local link write
   assign wrData = (link || linkWrite) ? returnAddr : normalData;

   assign wrAddr = linkWrite ? linkReg : writeRegAddr;  // Link write takes the port

   // The WB copy of a jump-and-link must not write again
   // Its register was already updated while it sat in decode
   assign wrEnable = (writeEn && !wbJl) || linkWrite;

endmodule

/* design/branchResolve.sv */
/*
   Branch resolution. Classifies the opcode, tests the first operand against
   the zero/sign condition and merges the result with the jump request into
   a single PC-select strobe.
*/
`timescale 1ns/1ns

module branchResolve import decodePkg::*; (
   input  opcodeT opcode,   // Opcode of the instruction in decode
   input  wordT   operand,  // First source register value (Rs)
   input  logic   jump,     // Unconditional redirect request
   input  logic   halt,     // Processor halting, never redirect
   output logic   pcSel     // High when the PC takes a new target
);

   logic       isBranch;   // One of the four conditional branches
   logic       isZero;
   logic       isNegative;
   logic       condMet;    // The selected condition holds
   branchCondT cond;

   // Only the four named branch opcodes count as branches
   always_comb begin
      case (opcode)
         opBeqz, opBnez, opBltz, opBgez: isBranch = 1'b1;
         default:                        isBranch = 1'b0;
      endcase
   end

   // Low opcode bits pick which test applies
   assign cond = branchCondT'(opcode[1:0]);

   assign isZero     = (operand == '0);
   assign isNegative = operand[$bits(wordT)-1];  // Two's complement sign bit

   always_comb begin
      condMet = 1'b0;
      case (cond)
         condEqz: condMet = isZero;
         condNez: condMet = !isZero;
         condLtz: condMet = isNegative;
         condGez: condMet = !isNegative;  // Zero counts as non-negative
         default: condMet = 1'b0;
      endcase
   end

   // Halt overrides both the branch outcome and a jump
   assign pcSel = !halt && ((isBranch && condMet) || jump);

endmodule

/* design/registerFile.sv */
/*
   Register file with eight 16-bit entries. Two combinational read ports and
   one synchronous write port, with the write data bypassed to any read of
   the register being written in the same cycle.
*/
`timescale 1ns/1ns

module registerFile import decodePkg::*; (
   input  logic    clk,
   input  logic    reset,      // Synchronous, clears every register
   input  regAddrT rd1Addr,    // First read port address
   input  regAddrT rd2Addr,    // Second read port address
   input  regAddrT wrAddr,     // Write port address
   input  wordT    wrData,     // Data stored at the next rising edge
   input  logic    wrEnable,   // Write strobe for this cycle
   output wordT    rd1Data,
   output wordT    rd2Data
);

   // One entry per value of the register index
   localparam int regCount = 1 << $bits(regAddrT);

   wordT regs [regCount];

   logic bypass1;  // Port 1 reads the register being written
   logic bypass2;  // Port 2 reads the register being written

   // Storage update
   // Reset wins over a write in the same cycle so the file comes up all zero
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < regCount; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEnable) begin
         regs[wrAddr] <= wrData;  // Single write per cycle
      end
   end

   // A read that hits the pending write returns the new value right away
   // This lets a writeback and a dependent decode share one cycle
   assign bypass1 = wrEnable && (wrAddr == rd1Addr);
   assign bypass2 = wrEnable && (wrAddr == rd2Addr);

   // Read muxes are purely combinational
   always_comb begin
      if (bypass1) begin
         rd1Data = wrData;  // Forward the value that lands at the next edge
      end else begin
         rd1Data = regs[rd1Addr];
      end
   end

   always_comb begin
      if (bypass2) begin
         rd2Data = wrData;
      end else begin
         rd2Data = regs[rd2Addr];  // Normal stored value
      end
   end

endmodule

/* design/decodePkg.sv */
/*
   Decode stage shared types and constants. Defines the data word, register
   index, opcode and branch-condition encodings, and the link register.
*/
package decodePkg;

   // One machine word, used for register data, PC values and instructions
   typedef logic [15:0] wordT;

   // Index into the eight-entry register file
   typedef logic [2:0] regAddrT;

   // Major opcode taken from instruction bits 15..11
   // Only the codes the decode stage acts on are named here
   typedef enum logic [4:0] {
      opJal  = 5'b00110,  // Jump and link with a PC relative target
      opJalr = 5'b00111,  // Jump and link through a register
      opBeqz = 5'b01100,  // Branch when Rs is zero
      opBnez = 5'b01101,  // Branch when Rs is not zero
      opBltz = 5'b01110,  // Branch when Rs is negative
      opBgez = 5'b01111   // Branch when Rs is zero or positive
   } opcodeT;

   // Branch condition held in the low two opcode bits (instruction bits 12..11)
   // The branch class shares bits 15..13 so these two bits pick the test
   typedef enum logic [1:0] {
      condEqz = 2'b00,  // Operand equals zero
      condNez = 2'b01,  // Operand differs from zero
      condLtz = 2'b10,  // Sign bit set
      condGez = 2'b11   // Sign bit clear
   } branchCondT;

   // Register that receives the return address of a jump-and-link
   localparam regAddrT linkReg = 3'd7;

   // Byte distance from one instruction to the next
   localparam wordT pcIncrement = 16'd2;

endpackage
